// File: Bender.yml
package:
  name: chain_processor

sources:
  - scope_cmd_pkg.sv
  - cmd_decoder.sv
  - reply_sender.sv
  - i2c_sequencer.sv
  - chain_processor.sv
  - target: test
    files:
      - chain_processor_assertions.sv
      - tb_chain_processor.sv

// File: chain_processor.sv
// one board of the chain, RAM_WIDTH sets the trigger point width and must be 5 to 16
`timescale 1ns/1ps

module chain_processor #(
	parameter int RAM_WIDTH = 12
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      rx_ready,
	input  scope_cmd_pkg::byte_t      rx_data,
	input  logic                      tx_busy,
	output logic                      tx_start,
	output scope_cmd_pkg::byte_t      tx_data,
	output scope_cmd_pkg::byte_t      com_data,     // byte for the next board
	output logic                      new_com_data,
	output logic                      serial_passthrough,
	output logic [1:0]                master_clock,
	output logic                      im_the_last,
	output logic                      im_the_first,
	output logic                      rolling_trigger,
	output logic [RAM_WIDTH-1:0]      trigger_point,
	output scope_cmd_pkg::byte_t      trig_thresh,
	output scope_cmd_pkg::chan_mask_t trig_channels,
	output scope_cmd_pkg::chan_mask_t gain_sw,
	input  logic [63:0]               chip_id,
	input  scope_cmd_pkg::byte_t      delay_counter, // tdc result
	output logic                      i2c_ena,
	output logic [6:0]                i2c_addr,
	output logic                      i2c_rw,
	output scope_cmd_pkg::byte_t      i2c_datawr,
	input  logic                      i2c_busy
);
	import scope_cmd_pkg::*;

	// decoder to reply sender
	logic                         reply_start;
	logic [3:0]                   reply_count;
	logic [8*REPLY_MAX_BYTES-1:0] reply_bytes;
	logic                         reply_done;
	// decoder to i2c sequencer
	logic                         i2c_req;
	logic [6:0]                   i2c_req_addr;
	logic [1:0]                   i2c_req_count;
	logic [8*I2C_BUF_BYTES-1:0]   i2c_req_bytes;
	logic                         i2c_ack;

	cmd_decoder #(.RAM_WIDTH(RAM_WIDTH)) u_cmd_decoder (.*);

	reply_sender u_reply_sender (.*);

	i2c_sequencer u_i2c_sequencer (.*);

endmodule

// File: chain_processor_assertions.sv
// handshake checks that bind to every chain_processor instance and stay blind during reset
`timescale 1ns/1ps

module chain_processor_assertions (
	input logic clk,
	input logic rst_n,
	input logic new_com_data,
	input logic reply_done,
	input logic tx_start,
	input logic tx_busy,
	input logic i2c_req,
	input logic i2c_ack
);

	int errors = 0; // failed checks so far

	// chain output is a single cycle strobe
	property single_com_pulse;
		@(posedge clk) disable iff (!rst_n) new_com_data |=> !new_com_data;
	endproperty

	property single_reply_done;
		@(posedge clk) disable iff (!rst_n) reply_done |=> !reply_done;
	endproperty

	// uart must be free when a byte is started
	property tx_start_when_free;
		@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy;
	endproperty

	property req_held_until_ack;
		@(posedge clk) disable iff (!rst_n) (i2c_req && !i2c_ack) |=> i2c_req;
	endproperty

	a_com_pulse: assert property (single_com_pulse) else begin
		$error("new_com_data held two cycles");
		errors++;
	end
	a_reply_done: assert property (single_reply_done) else begin
		$error("reply_done held two cycles");
		errors++;
	end
	a_tx_free: assert property (tx_start_when_free) else begin
		$error("tx_start while tx_busy high");
		errors++;
	end
	a_req_hold: assert property (req_held_until_ack) else begin
		$error("i2c_req dropped before ack");
		errors++;
	end

endmodule

bind chain_processor chain_processor_assertions u_assertions (
	.clk, .rst_n, .new_com_data, .reply_done, .tx_start, .tx_busy, .i2c_req, .i2c_ack
);

// File: cmd_decoder.sv
// one command at a time, rx bytes that arrive outside idle or read-more are lost and RAM_WIDTH must be 5 to 16
`timescale 1ns/1ps

module cmd_decoder #(
	parameter int RAM_WIDTH = 12
) (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       rx_ready,
	input  scope_cmd_pkg::byte_t                       rx_data,
	input  logic [63:0]                                chip_id,
	input  scope_cmd_pkg::byte_t                       delay_counter,
	input  logic                                       reply_done,
	input  logic                                       i2c_ack,
	output scope_cmd_pkg::byte_t                       com_data,
	output logic                                       new_com_data,
	output logic                                       serial_passthrough,
	output logic [1:0]                                 master_clock,
	output logic                                       im_the_last,
	output logic                                       im_the_first,
	output logic                                       rolling_trigger,
	output logic [RAM_WIDTH-1:0]                       trigger_point,
	output scope_cmd_pkg::byte_t                       trig_thresh,
	output scope_cmd_pkg::chan_mask_t                  trig_channels,
	output scope_cmd_pkg::chan_mask_t                  gain_sw,
	output logic                                       reply_start,
	output logic [3:0]                                 reply_count,
	output logic [8*scope_cmd_pkg::REPLY_MAX_BYTES-1:0] reply_bytes,
	output logic                                       i2c_req,
	output logic [6:0]                                 i2c_req_addr,
	output logic [1:0]                                 i2c_req_count,
	output logic [8*scope_cmd_pkg::I2C_BUF_BYTES-1:0]  i2c_req_bytes
);
	import scope_cmd_pkg::*;

	localparam int unsigned TP_MAX   = (1 << RAM_WIDTH) - TRIG_POINT_MARGIN;
	localparam int unsigned TP_RESET = 1 << (RAM_WIDTH - 2); // quarter of the window

	typedef enum logic [2:0] {S_IDLE, S_DECODE, S_READ_MORE, S_WAIT_REPLY, S_WAIT_I2C} state_t;

	state_t     state;
	byte_t      cmd;              // command byte under decode
	byte_t      arg_buf [5];      // argument bytes, longest is the raw i2c write
	logic [2:0] arg_cnt;          // arguments collected so far
	logic [2:0] args_needed;
	byte_t      arg_fwd;          // argument byte waiting one cycle to go down the chain
	logic       arg_fwd_v;
	board_id_t  board_id;
	chan_mask_t oversamp;         // 1 means no oversampling, only bits 0 and 1 matter
	logic       ch_hit;           // channel argument belongs to this board
	chan_mask_t ch_toggle;
	logic [15:0] tp_raw;

	assign im_the_first = (board_id == '0);
	assign ch_hit       = ({2'b00, arg_buf[0][7:2]} == board_id); // channel / 4
	assign ch_toggle    = ch_hit ? chan_mask_t'(4'b0001 << arg_buf[0][1:0]) : '0;
	assign tp_raw       = {arg_buf[0], arg_buf[1]};

	always_comb begin
		case (cmd)
			CMD_TRIG_POINT:                                      args_needed = 3'd2;
			CMD_TRIG_THRESH, CMD_TRIG_CHAN, CMD_GAIN, CMD_OVERSAMP: args_needed = 3'd1;
			CMD_I2C_RAW:                                         args_needed = 3'd5;
			default:                                             args_needed = 3'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state              <= S_IDLE;
			arg_cnt            <= '0;
			arg_fwd_v          <= 1'b0;
			new_com_data       <= 1'b0;
			board_id           <= BOARD_ID_UNASSIGNED;
			master_clock       <= 2'b00; // own clock master until an id arrives
			serial_passthrough <= 1'b0;
			im_the_last        <= 1'b0;
			rolling_trigger    <= 1'b1;
			trigger_point      <= RAM_WIDTH'(TP_RESET);
			trig_thresh        <= 8'h80; // mid scale
			trig_channels      <= '1;
			gain_sw            <= '0;    // low gain on all channels
			oversamp           <= 4'b0011;
			reply_start        <= 1'b0;
			i2c_req            <= 1'b0;
		end else begin
			new_com_data <= 1'b0;
			arg_fwd_v    <= 1'b0;
			reply_start  <= 1'b0;
			if (arg_fwd_v) begin // argument goes out 2 cycles after its rx_ready
				com_data     <= arg_fwd;
				new_com_data <= 1'b1;
			end
			case (state)
				S_IDLE: begin
					arg_cnt <= '0;
					if (rx_ready) begin
						cmd   <= rx_data;
						state <= S_DECODE;
					end
				end
				S_READ_MORE: if (rx_ready) begin
					arg_buf[arg_cnt] <= rx_data;
					arg_fwd          <= rx_data;
					arg_fwd_v        <= 1'b1;
					arg_cnt          <= arg_cnt + 3'd1;
					if (arg_cnt + 3'd1 == args_needed) state <= S_DECODE;
				end
				S_WAIT_REPLY: if (reply_done) state <= S_IDLE;
				S_WAIT_I2C: if (i2c_ack) begin // sequencer has copied the request
					i2c_req <= 1'b0;
					state   <= S_IDLE;
				end
				S_DECODE: begin
					state <= S_IDLE;
					if (arg_cnt < args_needed) begin // first pass, pass command on and collect args
						com_data     <= cmd;
						new_com_data <= 1'b1;
						state        <= S_READ_MORE;
					end else if (cmd < ID_CMD_LIMIT) begin
						board_id     <= cmd;
						master_clock <= (cmd == '0) ? 2'b00 : 2'b01; // others follow board 0
						com_data     <= cmd + 8'd1; // next board gets the next id
						new_com_data <= 1'b1;
					end else if (cmd >= LAST_CMD_BASE && cmd < LAST_CMD_BASE + RANGE_SPAN) begin
						im_the_last  <= (cmd - LAST_CMD_BASE == board_id);
						com_data     <= cmd;
						new_com_data <= 1'b1;
					end else if (cmd >= ACTIVE_CMD_BASE && cmd < ACTIVE_CMD_BASE + RANGE_SPAN) begin
						if (cmd - ACTIVE_CMD_BASE == board_id) serial_passthrough <= 1'b0;
						else begin
							serial_passthrough <= 1'b1; // another board talks, relay its bytes
							com_data           <= cmd;
							new_com_data       <= 1'b1;
						end
					end else begin
						case (cmd)
							CMD_ROLL_ON, CMD_ROLL_OFF: begin
								rolling_trigger <= (cmd == CMD_ROLL_ON);
								com_data        <= cmd;
								new_com_data    <= 1'b1;
							end
							CMD_TRIG_POINT: begin
								if (tp_raw > TP_MAX) trigger_point <= RAM_WIDTH'(TP_MAX);
								else if (tp_raw < TRIG_POINT_MIN)
									trigger_point <= RAM_WIDTH'(TRIG_POINT_MIN);
								else trigger_point <= RAM_WIDTH'(tp_raw);
							end
							CMD_TRIG_THRESH: trig_thresh <= arg_buf[0];
							CMD_TRIG_CHAN: trig_channels <= trig_channels ^ ch_toggle;
							CMD_GAIN, CMD_OVERSAMP: begin // both rewrite the whole expander port
								if (cmd == CMD_GAIN) begin
									gain_sw       <= gain_sw ^ ch_toggle;
									i2c_req_bytes <= {8'h00, oversamp, gain_sw ^ ch_toggle,
										EXPANDER_PORT_REG};
								end else begin
									oversamp      <= oversamp ^ ch_toggle;
									i2c_req_bytes <= {8'h00, oversamp ^ ch_toggle, gain_sw,
										EXPANDER_PORT_REG};
								end
								i2c_req_addr  <= EXPANDER_ADDR;
								i2c_req_count <= 2'd2;
								i2c_req       <= 1'b1;
								state         <= S_WAIT_I2C;
							end
							CMD_I2C_RAW: begin
								i2c_req_count <= (arg_buf[0] > I2C_BUF_BYTES) ?
									2'(I2C_BUF_BYTES) : arg_buf[0][1:0];
								i2c_req_addr  <= arg_buf[1][6:0];
								i2c_req_bytes <= {arg_buf[4], arg_buf[3], arg_buf[2]};
								i2c_req       <= 1'b1;
								state         <= S_WAIT_I2C;
							end
							CMD_TDC_DELAY, CMD_CHIP_ID: begin
								if (serial_passthrough) begin // not addressed to us
									com_data     <= cmd;
									new_com_data <= 1'b1;
								end else begin
									reply_bytes <= (cmd == CMD_CHIP_ID) ? chip_id : {56'h0, delay_counter};
									reply_count <= (cmd == CMD_CHIP_ID) ? 4'd8 : 4'd1;
									reply_start <= 1'b1;
									state       <= S_WAIT_REPLY;
								end
							end
							default: ; // unknown codes are dropped
						endcase
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: compile.f
scope_cmd_pkg.sv
cmd_decoder.sv
reply_sender.sv
i2c_sequencer.sv
chain_processor.sv
chain_processor_assertions.sv
tb_chain_processor.sv

// File: i2c_sequencer.sv
// write only, up to three data bytes per request and a request with count 0 is acknowledged and dropped
`timescale 1ns/1ps

module i2c_sequencer (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      i2c_req,
	input  logic [6:0]                                i2c_req_addr,
	input  logic [1:0]                                i2c_req_count,
	input  logic [8*scope_cmd_pkg::I2C_BUF_BYTES-1:0] i2c_req_bytes,
	input  logic                                      i2c_busy,
	output logic                                      i2c_ack,
	output logic                                      i2c_ena,
	output logic [6:0]                                i2c_addr,
	output logic                                      i2c_rw,
	output scope_cmd_pkg::byte_t                      i2c_datawr
);
	import scope_cmd_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_SEND, S_HOLD} state_t;

	state_t                     state;
	logic [8*I2C_BUF_BYTES-1:0] data_buf;
	logic [6:0]                 addr;
	logic [1:0]                 count;
	logic [1:0]                 taken;    // byte the master is working on
	logic [1:0]                 next_idx;

	assign i2c_ack  = i2c_req && (state == S_IDLE); // copy happens on this edge
	assign next_idx = taken + 2'd1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			i2c_ena <= 1'b0;
			i2c_rw  <= 1'b0;
			taken   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					i2c_ena <= 1'b0;
					if (i2c_req) begin
						data_buf <= i2c_req_bytes;
						addr     <= i2c_req_addr;
						count    <= i2c_req_count;
						if (i2c_req_count != '0) state <= S_WAIT;
					end
				end
				S_WAIT: if (!i2c_busy) begin // master idle, open the transfer
					i2c_addr   <= addr;
					i2c_rw     <= 1'b0;
					i2c_datawr <= data_buf[7:0];
					i2c_ena    <= 1'b1;
					taken      <= '0;
					state      <= S_SEND;
				end
				S_SEND: if (i2c_busy) begin // master latched the current byte
					if (next_idx < count) i2c_datawr <= data_buf[next_idx*8 +: 8];
					state <= S_HOLD;
				end
				S_HOLD: if (!i2c_busy) begin // one byte finished
					if (taken == count - 2'd1) begin
						i2c_ena <= 1'b0;
						state   <= S_IDLE;
					end else begin
						taken <= next_idx;
						state <= S_SEND;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: reply_sender.sv
// bytes go out lsb byte first and a reply_start with count 0 only returns reply_done
`timescale 1ns/1ps

module reply_sender (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       reply_start,
	input  logic [3:0]                                 reply_count,
	input  logic [8*scope_cmd_pkg::REPLY_MAX_BYTES-1:0] reply_bytes,
	input  logic                                       tx_busy,
	output logic                                       tx_start,
	output scope_cmd_pkg::byte_t                       tx_data,
	output logic                                       reply_done
);
	import scope_cmd_pkg::*;

	localparam int IDX_W = $clog2(REPLY_MAX_BYTES);

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_GAP} state_t;

	state_t                       state;
	logic [8*REPLY_MAX_BYTES-1:0] burst; // latched reply
	logic [3:0]                   count;
	logic [IDX_W-1:0]             idx;   // byte being sent

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			tx_start   <= 1'b0;
			reply_done <= 1'b0;
			idx        <= '0;
		end else begin
			tx_start   <= 1'b0;
			reply_done <= 1'b0;
			case (state)
				S_IDLE: if (reply_start) begin
					burst <= reply_bytes;
					count <= reply_count;
					idx   <= '0;
					if (reply_count == '0) reply_done <= 1'b1;
					else state <= S_WAIT;
				end
				S_WAIT: if (!tx_busy) begin // uart free, start one byte
					tx_data  <= burst[idx*8 +: 8];
					tx_start <= 1'b1;
					state    <= S_GAP;
				end
				S_GAP: begin // uart raises busy during this cycle
					if (4'(idx) + 4'd1 == count) begin
						reply_done <= 1'b1;
						state      <= S_IDLE;
					end else begin
						idx   <= idx + 1'b1;
						state <= S_WAIT;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: scope_cmd_pkg.sv
// codes assume the 8 bit serial command set of the chain and one board with 4 analog channels
package scope_cmd_pkg;

	typedef logic [7:0] byte_t;      // one serial or i2c byte
	typedef logic [7:0] board_id_t;  // position in the chain
	typedef logic [3:0] chan_mask_t; // one bit per analog channel

	localparam board_id_t BOARD_ID_UNASSIGNED = 8'd200; // no id received yet

	// single byte and argument commands
	localparam byte_t CMD_ROLL_ON     = 8'd101;
	localparam byte_t CMD_ROLL_OFF    = 8'd102;
	localparam byte_t CMD_TRIG_POINT  = 8'd121; // two argument bytes, msb first
	localparam byte_t CMD_TRIG_THRESH = 8'd127;
	localparam byte_t CMD_TRIG_CHAN   = 8'd130;
	localparam byte_t CMD_TDC_DELAY   = 8'd132; // one byte reply
	localparam byte_t CMD_GAIN        = 8'd134;
	localparam byte_t CMD_I2C_RAW     = 8'd136; // count, address, three data bytes
	localparam byte_t CMD_OVERSAMP    = 8'd141;
	localparam byte_t CMD_CHIP_ID     = 8'd142; // eight byte reply

	// ranged commands, each range is ten codes wide
	localparam byte_t ID_CMD_LIMIT    = 8'd10;
	localparam byte_t LAST_CMD_BASE   = 8'd20;
	localparam byte_t ACTIVE_CMD_BASE = 8'd30;
	localparam byte_t RANGE_SPAN      = 8'd10;

	localparam int I2C_BUF_BYTES   = 3;
	localparam int REPLY_MAX_BYTES = 8;

	// first mcp io expander, gain in port bits 3:0 and oversampling in 7:4
	localparam logic [6:0] EXPANDER_ADDR     = 7'h20;
	localparam byte_t      EXPANDER_PORT_REG = 8'h12;

	// trigger point is kept inside the sample ram window
	localparam int TRIG_POINT_MIN    = 4;
	localparam int TRIG_POINT_MARGIN = 16;

endpackage

// File: tb_chain_processor.sv
// one board only, the uart and the i2c master are simple models with lfsr driven delays
`timescale 1ns/1ps

module tb_chain_processor;
	import scope_cmd_pkg::*;

	localparam int RAM_WIDTH = 12;
	localparam int CYCLES_PER_ENTRY = 300; // longest entry is the chip id reply

	typedef struct {
		string                name;
		int                   ncmd;
		logic [47:0]          cmd;   // first byte in the top used byte
		int                   nfwd;
		logic [47:0]          fwd;
		int                   nrep;
		logic [63:0]          rep;
		int                   ni2c;
		logic [6:0]           i2c_addr;
		logic [23:0]          i2c;
		logic [1:0]           mc;
		logic                 last;
		logic                 pass;
		logic                 roll;
		logic [RAM_WIDTH-1:0] tp;
		byte_t                thresh;
		chan_mask_t           chans;
		chan_mask_t           gain;
		logic                 first;
	} entry_t;

	logic clk, rst_n, rx_ready, tx_busy, i2c_busy;
	byte_t rx_data, tx_data, com_data, trig_thresh, i2c_datawr;
	logic tx_start, new_com_data, serial_passthrough, im_the_last, im_the_first;
	logic rolling_trigger, i2c_ena, i2c_rw;
	logic [1:0] master_clock;
	logic [RAM_WIDTH-1:0] trigger_point;
	chan_mask_t trig_channels, gain_sw;
	logic [63:0] chip_id;
	byte_t delay_counter;
	logic [6:0] i2c_addr;

	entry_t table_q[$];
	byte_t com_q[$], tx_q[$], i2c_q[$]; // collected responses
	logic [6:0] i2c_addr_seen;
	logic i2c_rw_seen;
	byte_t lfsr = 8'd25;
	int cycles = 0;
	int limit = 0;

	chain_processor #(.RAM_WIDTH(RAM_WIDTH)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic int rand_bits(int n);
		int v;
		v = 0;
		repeat (n) begin
			v = (v << 1) | lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
		end
		return v;
	endfunction

	always @(posedge clk) begin
		if (new_com_data) com_q.push_back(com_data); // chain monitor
	end

	// uart transmitter model holds busy 1 to 8 cycles per byte
	initial begin
		tx_busy = 1'b0;
		forever begin
			@(posedge clk);
			if (tx_start) begin
				tx_q.push_back(tx_data);
				#1 tx_busy = 1'b1;
				repeat (1 + rand_bits(3)) @(posedge clk);
				#1 tx_busy = 1'b0;
			end
		end
	end

	// i2c master model takes a byte 1 to 4 cycles after ena and stays busy 2 to 9 cycles
	initial begin
		i2c_busy = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (i2c_ena) begin
				repeat (rand_bits(2)) begin
					@(posedge clk);
					#1;
				end
				i2c_q.push_back(i2c_datawr); // byte taken as busy rises
				i2c_addr_seen = i2c_addr;
				i2c_rw_seen   = i2c_rw;
				i2c_busy = 1'b1;
				repeat (2 + rand_bits(3)) begin
					@(posedge clk);
					#1;
				end
				i2c_busy = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (UUT.u_assertions.errors != 0) begin
			$display("a handshake assertion on the DUT failed");
			$display(">>> FAIL");
			$fatal(1);
		end else if (limit > 0 && cycles > limit) begin
			$display("timeout: the table did not finish within %0d cycles", limit);
			$display(">>> FAIL");
			$fatal(1);
		end
	end

	task automatic check_byte(string name, byte_t exp, byte_t act);
		if (exp !== act) begin
			$display("FAILED %s expected %02h actual %02h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_mask(string name, chan_mask_t exp, chan_mask_t act);
		if (exp !== act) begin
			$display("FAILED %s expected %04b actual %04b", name, exp, act);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_point(string name, logic [RAM_WIDTH-1:0] exp,
		logic [RAM_WIDTH-1:0] act);
		if (exp !== act) begin
			$display("FAILED %s expected %0d actual %0d", name, exp, act);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	task automatic add_entry(string name, int ncmd, logic [47:0] cmd, int nfwd, logic [47:0] fwd,
		int nrep, logic [63:0] rep, int ni2c, logic [6:0] ia, logic [23:0] ib,
		logic [1:0] mc, logic last, logic pass, logic roll, int tp, byte_t th,
		chan_mask_t ch, chan_mask_t g, logic first);
		entry_t e;
		e = '{name, ncmd, cmd, nfwd, fwd, nrep, rep, ni2c, ia, ib, mc, last, pass, roll,
			RAM_WIDTH'(tp), th, ch, g, first};
		table_q.push_back(e);
	endtask

	task automatic send_byte(byte_t b);
		@(posedge clk);
		#1;
		rx_ready = 1'b1;
		rx_data  = b;
		@(posedge clk);
		#1;
		rx_ready = 1'b0;
		repeat (3) @(posedge clk); // serial gap between bytes
	endtask

	task automatic run_entry(entry_t e);
		com_q.delete();
		tx_q.delete();
		i2c_q.delete();
		for (int k = 0; k < e.ncmd; k++) send_byte(e.cmd[8*(e.ncmd-1-k) +: 8]);
		while (tx_q.size() < e.nrep || i2c_q.size() < e.ni2c || i2c_ena) @(posedge clk);
		repeat (6) @(posedge clk); // let forwarding and config settle
		#1;
		check_byte({e.name, " forward count"}, byte_t'(e.nfwd), byte_t'(com_q.size()));
		check_byte({e.name, " reply count"}, byte_t'(e.nrep), byte_t'(tx_q.size()));
		check_byte({e.name, " i2c count"}, byte_t'(e.ni2c), byte_t'(i2c_q.size()));
		for (int k = 0; k < e.nfwd; k++)
			check_byte($sformatf("%s fwd %0d", e.name, k), e.fwd[8*(e.nfwd-1-k) +: 8], com_q[k]);
		for (int k = 0; k < e.nrep; k++)
			check_byte($sformatf("%s reply %0d", e.name, k), e.rep[8*(e.nrep-1-k) +: 8], tx_q[k]);
		for (int k = 0; k < e.ni2c; k++)
			check_byte($sformatf("%s i2c %0d", e.name, k), e.i2c[8*(e.ni2c-1-k) +: 8], i2c_q[k]);
		if (e.ni2c > 0) begin
			check_byte({e.name, " i2c addr"}, {1'b0, e.i2c_addr}, {1'b0, i2c_addr_seen});
			check_byte({e.name, " i2c rw"}, 8'h00, byte_t'(i2c_rw_seen)); // writes only
		end
		check_byte({e.name, " master_clock"}, byte_t'(e.mc), byte_t'(master_clock));
		check_byte({e.name, " im_the_last"}, byte_t'(e.last), byte_t'(im_the_last));
		check_byte({e.name, " im_the_first"}, byte_t'(e.first), byte_t'(im_the_first));
		check_byte({e.name, " passthrough"}, byte_t'(e.pass), byte_t'(serial_passthrough));
		check_byte({e.name, " rolling"}, byte_t'(e.roll), byte_t'(rolling_trigger));
		check_point({e.name, " trigger_point"}, e.tp, trigger_point);
		check_byte({e.name, " thresh"}, e.thresh, trig_thresh);
		check_mask({e.name, " trig_channels"}, e.chans, trig_channels);
		check_mask({e.name, " gain"}, e.gain, gain_sw);
	endtask

	initial begin
		rst_n         = 1'b0;
		rx_ready      = 1'b0;
		rx_data       = '0;
		chip_id       = 64'h0123_4567_89AB_CDEF;
		delay_counter = 8'h5A;
		// state carries over so each row holds the config after its command
		add_entry("id_zero", 1, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1024, 8'h80, 4'hF, 0, 1);
		add_entry("set_id", 1, 3, 1, 4, 0, 0, 0, 0, 0, 1, 0, 0, 1, 1024, 8'h80, 4'hF, 0, 0);
		add_entry("last_on", 1, 23, 1, 23, 0, 0, 0, 0, 0,
			1, 1, 0, 1, 1024, 8'h80, 4'hF, 0, 0);
		add_entry("last_off", 1, 22, 1, 22, 0, 0, 0, 0, 0,
			1, 0, 0, 1, 1024, 8'h80, 4'hF, 0, 0);
		add_entry("active", 1, 33, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 1024, 8'h80, 4'hF, 0, 0);
		add_entry("other_active", 1, 31, 1, 31, 0, 0, 0, 0, 0,
			1, 0, 1, 1, 1024, 8'h80, 4'hF, 0, 0);
		add_entry("chip_id_relay", 1, 142, 1, 142, 0, 0, 0, 0, 0, 1, 0, 1, 1, 1024, 8'h80,
			4'hF, 0, 0);
		add_entry("active_again", 1, 33, 0, 0, 0, 0, 0, 0, 0,
			1, 0, 0, 1, 1024, 8'h80, 4'hF, 0, 0);
		add_entry("chip_id", 1, 142, 0, 0, 8, 64'hEFCD_AB89_6745_2301, 0, 0, 0,
			1, 0, 0, 1, 1024, 8'h80, 4'hF, 0, 0);
		add_entry("tp_min", 3, {8'd121, 8'h00, 8'h01}, 3, {8'd121, 8'h00, 8'h01}, 0, 0, 0, 0, 0,
			1, 0, 0, 1, 4, 8'h80, 4'hF, 0, 0);
		add_entry("tp_max", 3, {8'd121, 8'hFF, 8'hFF}, 3, {8'd121, 8'hFF, 8'hFF}, 0, 0, 0, 0, 0,
			1, 0, 0, 1, 4080, 8'h80, 4'hF, 0, 0);
		add_entry("trig_chan", 2, {8'd130, 8'd13}, 2, {8'd130, 8'd13}, 0, 0, 0, 0, 0,
			1, 0, 0, 1, 4080, 8'h80, 4'hD, 0, 0);
		add_entry("trig_other", 2, {8'd130, 8'd5}, 2, {8'd130, 8'd5}, 0, 0, 0, 0, 0,
			1, 0, 0, 1, 4080, 8'h80, 4'hD, 0, 0);
		add_entry("thresh", 2, {8'd127, 8'h40}, 2, {8'd127, 8'h40}, 0, 0, 0, 0, 0,
			1, 0, 0, 1, 4080, 8'h40, 4'hD, 0, 0);
		add_entry("roll_off", 1, 102, 1, 102, 0, 0, 0, 0, 0,
			1, 0, 0, 0, 4080, 8'h40, 4'hD, 0, 0);
		add_entry("roll_on", 1, 101, 1, 101, 0, 0, 0, 0, 0,
			1, 0, 0, 1, 4080, 8'h40, 4'hD, 0, 0);
		add_entry("gain", 2, {8'd134, 8'd12}, 2, {8'd134, 8'd12}, 0, 0, 2, 7'h20, 16'h1231,
			1, 0, 0, 1, 4080, 8'h40, 4'hD, 4'h1, 0);
		add_entry("oversamp", 2, {8'd141, 8'd12}, 2, {8'd141, 8'd12}, 0, 0, 2, 7'h20, 16'h1221,
			1, 0, 0, 1, 4080, 8'h40, 4'hD, 4'h1, 0);
		add_entry("i2c_raw", 6, 48'h88_03_60_A1_B2_C3, 6, 48'h88_03_60_A1_B2_C3, 0, 0,
			3, 7'h60, 24'hA1B2C3, 1, 0, 0, 1, 4080, 8'h40, 4'hD, 4'h1, 0);
		add_entry("tdc_delay", 1, 132, 0, 0, 1, 8'h5A, 0, 0, 0, 1, 0, 0, 1, 4080, 8'h40,
			4'hD, 4'h1, 0);
		limit = table_q.size() * CYCLES_PER_ENTRY;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		foreach (table_q[i]) run_entry(table_q[i]);
		if (UUT.u_assertions.errors == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("%0d handshake assertions on the DUT failed", UUT.u_assertions.errors);
			$display(">>> FAIL");
			$fatal(1);
		end
	end

endmodule
